// ==== hdl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// machine word, shared by data values and instructions
`define CPU_DATA_W 16

// address field of an instruction
// also the width of pc and mar
`define CPU_ADDR_W 12

// one word per address, full 12-bit space
`define CPU_MEM_DEPTH 4096

// opcode (4) plus address (12) must fill a data word exactly,
// since memory words are decoded either way

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // instruction set, upper nibble of an instruction word
    typedef enum logic [3:0] {
        OP_HALT  = 4'h0,
        OP_LOAD  = 4'h1,
        OP_STORE = 4'h2,
        OP_ADD   = 4'h3,
        OP_SUB   = 4'h4,
        OP_AND   = 4'h5,
        OP_OR    = 4'h6,
        OP_XOR   = 4'h7,
        OP_MUL   = 4'h8,
        // acc-only, address field ignored
        OP_SHL   = 4'h9,
        OP_SHR   = 4'ha,
        OP_ROL   = 4'hb,
        OP_JMP   = 4'hc,
        // taken when acc is zero
        OP_JZ    = 4'hd,
        OP_OUT   = 4'he,
        // 12-bit field, zero extended
        OP_LDI   = 4'hf
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_OR     = 4'h3,
        ALU_XOR    = 4'h4,
        ALU_MUL    = 4'h5,
        ALU_SHL    = 4'h6,
        ALU_SHR    = 4'h7,
        ALU_ROL    = 4'h8,
        ALU_PASS_B = 4'h9
    } alu_op_e;

    typedef struct packed {
        opcode_e                 opcode;
        logic [`CPU_ADDR_W-1:0]  addr;
    } instr_t;

    // a memory word seen as data or as an instruction
    typedef union packed {
        logic [`CPU_DATA_W-1:0]  data;
        instr_t                  instr;
    } mem_word_u;

    // program load beat
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0]  addr;
        logic [`CPU_DATA_W-1:0]  data;
    } load_req_t;

    // control unit to datapath and memory
    typedef struct packed {
        logic     pc_clr;
        logic     pc_load;
        logic     pc_inc;
        logic     mar_from_pc;
        logic     mar_we;
        logic     ir_we;
        logic     mbr_we;
        logic     acc_we;
        // ALU operand b from ir field instead of mbr
        logic     imm_sel;
        logic     mem_we;
        alu_op_e  alu_op;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
    input  wire cpu_pkg::alu_op_e     alu_op,
    input  wire [`CPU_DATA_W-1:0]     a,
    input  wire [`CPU_DATA_W-1:0]     b,
    output logic [`CPU_DATA_W-1:0]    result
);
    import cpu_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            // low half of the product only
            ALU_MUL: result = a * b;
            // single-bit shifts of a only
            ALU_SHL: result = {a[`CPU_DATA_W-2:0], 1'b0};
            ALU_SHR: result = {1'b0, a[`CPU_DATA_W-1:1]};
            // msb wraps into bit 0
            ALU_ROL: result = {a[`CPU_DATA_W-2:0], a[`CPU_DATA_W-1]};
            // loads and immediates
            ALU_PASS_B: result = b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module main_memory (
    input  wire                        clk,
    input  wire [`CPU_ADDR_W-1:0]      cpu_addr,
    input  wire [`CPU_DATA_W-1:0]      wdata,
    input  wire                        mem_we,
    input  wire                        prog_we,
    input  wire cpu_pkg::load_req_t    load,
    output cpu_pkg::mem_word_u         rdata
);

    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

    // one access per cycle
    // program load wins, only active while the cpu is idle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[load.addr] <= load.data;
        end else if (mem_we) begin
            // STORE of acc at mar
            mem[cpu_addr] <= wdata;
        end else begin
            // registered read, valid the cycle after
            rdata.data <= mem[cpu_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module control_unit (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire cpu_pkg::opcode_e     opcode,
    input  wire                       acc_zero,
    input  wire                       start,
    input  wire                       load_valid,
    output logic                      load_ready,
    output logic                      prog_we,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic                      halted,
    output cpu_pkg::ctrl_t            ctrl
);
    import cpu_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        // mar <= pc
        S_FETCH,
        // memory reads instruction word
        S_FETCH_RD,
        // ir/mbr load, pc increment
        S_DECODE,
        // ir valid, dispatch on opcode
        S_EXEC,
        S_MEM_RD,
        S_MEM_ACC,
        S_STORE,
        S_OUT_WAIT
    } state_e;

    state_e state_q;
    state_e state_d;

    // opcode to alu function
    function automatic alu_op_e alu_op_for(input opcode_e op);
        case (op)
            OP_ADD:  return ALU_ADD;
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_XOR:  return ALU_XOR;
            OP_MUL:  return ALU_MUL;
            OP_SHL:  return ALU_SHL;
            OP_SHR:  return ALU_SHR;
            OP_ROL:  return ALU_ROL;
            OP_LOAD: return ALU_PASS_B;
            OP_LDI:  return ALU_PASS_B;
            default: return ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        ctrl        = '0;
        ctrl.alu_op = alu_op_for(opcode);
        load_ready  = 1'b0;
        prog_we     = 1'b0;
        out_valid   = 1'b0;
        halted      = 1'b0;

        case (state_q)
            S_IDLE: begin
                load_ready = 1'b1;
                prog_we    = load_valid;
                // a completing load beat blocks start
                if (start && !load_valid) begin
                    ctrl.pc_clr = 1'b1;
                    state_d     = S_FETCH;
                end
            end
            S_FETCH: begin
                ctrl.mar_we      = 1'b1;
                ctrl.mar_from_pc = 1'b1;
                state_d          = S_FETCH_RD;
            end
            S_FETCH_RD: begin
                state_d = S_DECODE;
            end
            S_DECODE: begin
                ctrl.ir_we  = 1'b1;
                ctrl.mbr_we = 1'b1;
                ctrl.pc_inc = 1'b1;
                state_d     = S_EXEC;
            end
            S_EXEC: begin
                case (opcode)
                    OP_HALT: begin
                        // back to idle next cycle
                        halted  = 1'b1;
                        state_d = S_IDLE;
                    end
                    OP_LDI, OP_SHL, OP_SHR, OP_ROL: begin
                        ctrl.acc_we  = 1'b1;
                        ctrl.imm_sel = (opcode == OP_LDI);
                        state_d      = S_FETCH;
                    end
                    OP_JMP: begin
                        ctrl.pc_load = 1'b1;
                        state_d      = S_FETCH;
                    end
                    OP_JZ: begin
                        ctrl.pc_load = acc_zero;
                        state_d      = S_FETCH;
                    end
                    OP_OUT: begin
                        // acc is out_data, held until accepted
                        out_valid = 1'b1;
                        state_d   = out_ready ? S_FETCH : S_OUT_WAIT;
                    end
                    OP_STORE: begin
                        // mar <= ir address
                        ctrl.mar_we = 1'b1;
                        state_d     = S_STORE;
                    end
                    OP_LOAD, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MUL: begin
                        ctrl.mar_we = 1'b1;
                        state_d     = S_MEM_RD;
                    end
                    default: begin
                        state_d = S_FETCH;
                    end
                endcase
            end
            S_MEM_RD: begin
                state_d = S_MEM_ACC;
            end
            S_MEM_ACC: begin
                // operand passes through mbr into the alu
                ctrl.mbr_we = 1'b1;
                ctrl.acc_we = 1'b1;
                state_d     = S_FETCH;
            end
            S_STORE: begin
                ctrl.mem_we = 1'b1;
                state_d     = S_FETCH;
            end
            S_OUT_WAIT: begin
                // stalled on back-pressure
                out_valid = 1'b1;
                if (out_ready) begin
                    state_d = S_FETCH;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module datapath (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire cpu_pkg::ctrl_t       ctrl,
    input  wire cpu_pkg::mem_word_u   rdata,
    output logic [`CPU_ADDR_W-1:0]    mem_addr,
    output logic [`CPU_DATA_W-1:0]    acc,
    output cpu_pkg::opcode_e          opcode,
    output logic                      acc_zero
);
    import cpu_pkg::*;

    logic [`CPU_ADDR_W-1:0] pc_q;
    logic [`CPU_ADDR_W-1:0] mar_q;
    logic [`CPU_DATA_W-1:0] mbr_q;
    logic [`CPU_DATA_W-1:0] acc_q;
    instr_t                 ir_q;

    logic [`CPU_DATA_W-1:0] imm_ext;
    logic [`CPU_DATA_W-1:0] mem_data;
    logic [`CPU_DATA_W-1:0] operand_b;
    logic [`CPU_DATA_W-1:0] alu_result;

    // program counter
    // clear on start, jump target from ir, else step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (ctrl.pc_clr) begin
            pc_q <= '0;
        end else if (ctrl.pc_load) begin
            pc_q <= ir_q.addr;
        end else if (ctrl.pc_inc) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    // mar drives the memory address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mar_q <= '0;
        end else if (ctrl.mar_we) begin
            mar_q <= ctrl.mar_from_pc ? pc_q : ir_q.addr;
        end
    end

    // ir and mbr both capture the memory word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_q  <= '0;
            mbr_q <= '0;
        end else begin
            if (ctrl.ir_we) begin
                ir_q <= rdata.instr;
            end
            if (ctrl.mbr_we) begin
                mbr_q <= rdata.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (ctrl.acc_we) begin
            acc_q <= alu_result;
        end
    end

    // ldi immediate, zero extended
    assign imm_ext = {{(`CPU_DATA_W-`CPU_ADDR_W){1'b0}}, ir_q.addr};

    // mbr write-through
    // lets the alu use the operand in the same cycle it is captured
    assign mem_data  = ctrl.mbr_we ? rdata.data : mbr_q;
    assign operand_b = ctrl.imm_sel ? imm_ext : mem_data;

    alu u_alu (
        .alu_op (ctrl.alu_op),
        .a      (acc_q),
        .b      (operand_b),
        .result (alu_result)
    );

    assign mem_addr = mar_q;
    assign acc      = acc_q;
    assign opcode   = ir_q.opcode;
    // for jz
    assign acc_zero = (acc_q == '0);

endmodule

`default_nettype wire

// ==== hdl/computer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module computer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       start,
    input  wire                       load_valid,
    output logic                      load_ready,
    input  wire cpu_pkg::load_req_t   load,
    output logic                      out_valid,
    input  wire                       out_ready,
    output logic [`CPU_DATA_W-1:0]    out_data,
    output logic                      halted
);
    import cpu_pkg::*;

    ctrl_t                  ctrl;
    mem_word_u              rdata;
    opcode_e                opcode;
    logic                   acc_zero;
    logic                   prog_we;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic [`CPU_DATA_W-1:0] acc;

    control_unit u_control_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .acc_zero   (acc_zero),
        .start      (start),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .prog_we    (prog_we),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .halted     (halted),
        .ctrl       (ctrl)
    );

    datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .rdata    (rdata),
        .mem_addr (mem_addr),
        .acc      (acc),
        .opcode   (opcode),
        .acc_zero (acc_zero)
    );

    // store data is always acc
    main_memory u_main_memory (
        .clk      (clk),
        .cpu_addr (mem_addr),
        .wdata    (acc),
        .mem_we   (ctrl.mem_we),
        .prog_we  (prog_we),
        .load     (load),
        .rdata    (rdata)
    );

    assign out_data = acc;

endmodule

`default_nettype wire

// ==== sim/tb_iss.svh ====
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// instruction-set model of the accumulator machine
// runs from address 0 until HALT and collects every OUT value
// returns the number of instructions executed, -1 if no HALT is reached
function automatic int iss_run(
    input  logic [`CPU_DATA_W-1:0] mem_in  [`CPU_MEM_DEPTH],
    output logic [`CPU_DATA_W-1:0] mem_out [`CPU_MEM_DEPTH],
    output logic [`CPU_DATA_W-1:0] outs    [$]
);
    logic [`CPU_DATA_W-1:0] m [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] acc;
    logic [`CPU_DATA_W-1:0] word;
    logic [`CPU_DATA_W-1:0] opnd;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [3:0]             op;
    int                     steps;
    m    = mem_in;
    outs = {};
    acc  = '0;
    pc   = '0;
    for (steps = 1; steps < 10000; steps++) begin
        word = m[pc];
        op   = word[`CPU_DATA_W-1:`CPU_ADDR_W];
        addr = word[`CPU_ADDR_W-1:0];
        opnd = m[addr];
        // pc moves on before execute, jumps overwrite it
        pc   = pc + 1'b1;
        case (op)
            OP_HALT: begin
                mem_out = m;
                return steps;
            end
            OP_LOAD:  acc = opnd;
            OP_STORE: m[addr] = acc;
            OP_ADD:   acc = acc + opnd;
            OP_SUB:   acc = acc - opnd;
            OP_AND:   acc = acc & opnd;
            OP_OR:    acc = acc | opnd;
            OP_XOR:   acc = acc ^ opnd;
            // low 16 bits of the product
            OP_MUL:   acc = acc * opnd;
            OP_SHL:   acc = {acc[14:0], 1'b0};
            OP_SHR:   acc = {1'b0, acc[15:1]};
            OP_ROL:   acc = {acc[14:0], acc[15]};
            OP_JMP:   pc = addr;
            OP_JZ: begin
                if (acc == '0) begin
                    pc = addr;
                end
            end
            OP_OUT:   outs.push_back(acc);
            // immediate, zero extended
            default:  acc = {4'h0, addr};
        endcase
    end
    // runaway program
    mem_out = m;
    return -1;
endfunction

`endif

// ==== sim/tb_computer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_computer;
    import cpu_pkg::*;

    localparam int NUM_PROGS = 4;
    localparam int PROG_LEN  = 32;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic                   load_valid;
    logic                   load_ready;
    load_req_t              load;
    logic                   out_valid;
    logic                   out_ready;
    logic [`CPU_DATA_W-1:0] out_data;
    logic                   halted;

    // program image and model state
    logic [`CPU_DATA_W-1:0] prog      [PROG_LEN];
    logic [`CPU_DATA_W-1:0] model_mem [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] mem_after [`CPU_MEM_DEPTH];
    logic [`CPU_DATA_W-1:0] prog_outs [$];
    logic [`CPU_DATA_W-1:0] exp_q     [$];
    int                     exp_through [NUM_PROGS];

    integer                 seed = 32'h2181_81a6;
    logic [31:0]            rnd;
    int                     errors;
    int                     out_count;
    int                     halt_count;
    int                     cycles;
    int                     cycle_limit;
    logic                   hold_pending;
    logic [`CPU_DATA_W-1:0] held_data;
    logic [`CPU_DATA_W-1:0] expected;

    `include "tb_iss.svh"

    computer u_computer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .load       (load),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .halted     (halted)
    );

    always #5 clk = ~clk;

    function automatic logic [`CPU_DATA_W-1:0] encode(input opcode_e op,
                                                      input logic [`CPU_ADDR_W-1:0] a);
        return {op, a};
    endfunction

    // unused words hold HALT with the word's own address in the field
    task automatic build_program(input int p);
        int i;
        for (i = 0; i < PROG_LEN; i++) begin
            prog[i] = {4'h0, 12'(i)};
        end
        case (p)
            // arithmetic, wraps on SUB
            0: begin
                prog[0]     = encode(OP_LDI, 12'h123);
                prog[1]     = encode(OP_OUT, 12'h000);
                prog[2]     = encode(OP_ADD, 12'h018);
                prog[3]     = encode(OP_OUT, 12'h000);
                prog[4]     = encode(OP_SUB, 12'h019);
                prog[5]     = encode(OP_OUT, 12'h000);
                prog[6]     = encode(OP_MUL, 12'h01a);
                prog[7]     = encode(OP_OUT, 12'h000);
                prog[8]     = encode(OP_HALT, 12'h000);
                prog[8'h18] = 16'h7ff0;
                prog[8'h19] = 16'h9000;
                prog[8'h1a] = 16'h0123;
            end
            // logic and shifts on edge values
            1: begin
                prog[0]     = encode(OP_LOAD, 12'h018);
                prog[1]     = encode(OP_ROL, 12'h000);
                prog[2]     = encode(OP_OUT, 12'h000);
                prog[3]     = encode(OP_LOAD, 12'h018);
                prog[4]     = encode(OP_SHL, 12'h000);
                prog[5]     = encode(OP_OUT, 12'h000);
                prog[6]     = encode(OP_LOAD, 12'h018);
                prog[7]     = encode(OP_SHR, 12'h000);
                prog[8]     = encode(OP_OUT, 12'h000);
                prog[9]     = encode(OP_XOR, 12'h019);
                prog[10]    = encode(OP_OUT, 12'h000);
                prog[11]    = encode(OP_AND, 12'h01a);
                prog[12]    = encode(OP_OUT, 12'h000);
                prog[13]    = encode(OP_OR, 12'h018);
                prog[14]    = encode(OP_OUT, 12'h000);
                prog[15]    = encode(OP_ROL, 12'h000);
                prog[16]    = encode(OP_OUT, 12'h000);
                prog[17]    = encode(OP_HALT, 12'h000);
                prog[8'h18] = 16'h8001;
                prog[8'h19] = 16'hffff;
                prog[8'h1a] = 16'h0f0f;
            end
            // store, reload, then a data word rewritten by the program
            2: begin
                prog[0]     = encode(OP_LDI, 12'habc);
                prog[1]     = encode(OP_STORE, 12'h018);
                prog[2]     = encode(OP_LDI, 12'h000);
                prog[3]     = encode(OP_LOAD, 12'h018);
                prog[4]     = encode(OP_OUT, 12'h000);
                prog[5]     = encode(OP_ADD, 12'h019);
                prog[6]     = encode(OP_STORE, 12'h019);
                prog[7]     = encode(OP_LDI, 12'h001);
                prog[8]     = encode(OP_LOAD, 12'h019);
                prog[9]     = encode(OP_OUT, 12'h000);
                prog[10]    = encode(OP_ADD, 12'h019);
                prog[11]    = encode(OP_OUT, 12'h000);
                prog[12]    = encode(OP_HALT, 12'h000);
                prog[8'h19] = 16'h1111;
            end
            // countdown loop, 5 down to 1, then a marker
            default: begin
                prog[0]     = encode(OP_LDI, 12'h005);
                prog[1]     = encode(OP_STORE, 12'h018);
                prog[2]     = encode(OP_LOAD, 12'h018);
                prog[3]     = encode(OP_OUT, 12'h000);
                prog[4]     = encode(OP_SUB, 12'h019);
                prog[5]     = encode(OP_STORE, 12'h018);
                prog[6]     = encode(OP_JZ, 12'h008);
                prog[7]     = encode(OP_JMP, 12'h002);
                prog[8]     = encode(OP_LDI, 12'hfed);
                prog[9]     = encode(OP_OUT, 12'h000);
                prog[10]    = encode(OP_HALT, 12'h000);
                prog[8'h19] = 16'h0001;
            end
        endcase
    endtask

    // one word per valid/ready handshake, called on a rising edge
    task automatic load_program();
        int i;
        for (i = 0; i < PROG_LEN; i++) begin
            load_valid <= 1'b1;
            load       <= '{addr: 12'(i), data: prog[i]};
            @(posedge clk);
            while (!load_ready) begin
                @(posedge clk);
            end
        end
        load_valid <= 1'b0;
    endtask

    // random back-pressure
    always @(posedge clk) begin
        rnd = $random(seed);
        out_ready <= rnd[0];
    end

    // compare process, checks each accepted output and the held value
    always @(posedge clk) begin
        if (rst_n) begin
            if (hold_pending) begin
                if (!out_valid) begin
                    $display("out_valid dropped at %0t before out_ready was seen", $time);
                    errors++;
                end else if (out_data !== held_data) begin
                    $display("Fail at %0t: out_data (held) expected %h, got %h",
                             $time, held_data, out_data);
                    errors++;
                end
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    $display("extra output %h at %0t, none was expected", out_data, $time);
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    if (out_data !== expected) begin
                        $display("Fail at %0t: out_data expected %h, got %h",
                                 $time, expected, out_data);
                        errors++;
                    end
                end
            end
            if (halted) begin
                halt_count++;
            end
            hold_pending = out_valid && !out_ready;
            held_data    = out_data;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a halt or an output never came", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int p;
        int i;
        int n;
        int total_steps;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        load_valid   = 1'b0;
        load         = '0;
        out_ready    = 1'b0;
        errors       = 0;
        out_count    = 0;
        halt_count   = 0;
        cycles       = 0;
        hold_pending = 1'b0;
        held_data    = '0;
        total_steps  = 0;
        for (i = 0; i < `CPU_MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end

        // model every program first so the run limit is known
        for (p = 0; p < NUM_PROGS; p++) begin
            build_program(p);
            for (i = 0; i < PROG_LEN; i++) begin
                model_mem[i] = prog[i];
            end
            n = iss_run(model_mem, mem_after, prog_outs);
            model_mem = mem_after;
            if (n < 0) begin
                $display("model of program %0d never reaches HALT", p);
                errors++;
                n = 0;
            end
            total_steps += n;
            foreach (prog_outs[i]) begin
                exp_q.push_back(prog_outs[i]);
            end
            exp_through[p] = exp_q.size();
        end
        cycle_limit = 40 * total_steps + NUM_PROGS * (PROG_LEN + 10) + 20;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (p = 0; p < NUM_PROGS; p++) begin
            build_program(p);
            if (!load_ready) begin
                $display("load_ready low at %0t while idle before program %0d", $time, p);
                errors++;
            end
            load_program();
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            @(posedge clk);
            while (!halted) begin
                @(posedge clk);
            end
            // idle again one cycle after the halt pulse
            @(negedge clk);
            if (halted || !load_ready) begin
                $display("machine not idle after halt of program %0d", p);
                errors++;
            end
            if (halt_count != p + 1) begin
                $display("halted pulsed %0d times by program %0d", halt_count, p);
                errors++;
            end
            if (out_count != exp_through[p]) begin
                $display("program %0d gave %0d outputs in total, model gives %0d",
                         p, out_count, exp_through[p]);
                errors++;
            end
            @(posedge clk);
        end

        @(negedge clk);
        $display("errors: %0d, outputs checked: %0d", errors, out_count);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
+incdir+sim
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/main_memory.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/computer.sv
sim/tb_computer.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_computer
RTL_TOP   ?= computer
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINT_OPTS ?= --lint-only -Wall
RTL_SRCS  ?= hdl/cpu_pkg.sv hdl/alu.sv hdl/main_memory.sv \
             hdl/control_unit.sv hdl/datapath.sv hdl/computer.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the simulation prints the pass message
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_OPTS) -Ihdl $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
